//--- Bender.yml
package:
  name: amber_sys

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/amber_sys_pkg.sv
      - rtl/boot_mem.sv
      - rtl/wb_decoder.sv
      - timer/timer_channel.sv
      - timer/timer_regs.sv
      - irq/irq_ctrl.sv
      - rtl/amber_sys.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/tb_amber_sys.sv

//--- common/amber_sys_defs.svh
// Address map, register offsets, sizes and interrupt bit positions

`ifndef AMBER_SYS_DEFS_SVH
`define AMBER_SYS_DEFS_SVH

// Regions, matched against address bits 31:24
`define AMBER_REGION_BOOT       8'h00
`define AMBER_REGION_TIMER      8'h13
`define AMBER_REGION_IRQ        8'h14

// Boot SRAM geometry
`define AMBER_BOOT_WORDS        256
`define AMBER_BOOT_AW           8

// Timer block, channel index sits in address bits 9:8
`define AMBER_TIMERS            3
`define AMBER_TIMER_STRIDE_BIT  8
`define AMBER_TIMER_LOAD        8'h00
`define AMBER_TIMER_VALUE       8'h04
`define AMBER_TIMER_CTRL        8'h08
`define AMBER_TIMER_CLEAR       8'h0C

// Control word bits
`define AMBER_CTRL_ENABLE_BIT   7
`define AMBER_CTRL_PERIODIC_BIT 6

// Interrupt controller, IRQ half
`define AMBER_IRQ_STATUS        8'h00
`define AMBER_IRQ_RAW           8'h04
`define AMBER_IRQ_EN_SET        8'h08
`define AMBER_IRQ_EN_CLR        8'h0C

// FIRQ half mirrors the IRQ layout at +0x20
`define AMBER_FIRQ_STATUS       8'h20
`define AMBER_FIRQ_RAW          8'h24
`define AMBER_FIRQ_EN_SET       8'h28
`define AMBER_FIRQ_EN_CLR       8'h2C

// Software interrupt
`define AMBER_SOFT_SET          8'h30
`define AMBER_SOFT_CLR          8'h34

// Raw vector bit positions, timer k on bit LSB+k
`define AMBER_IRQ_SOFT_BIT      1
`define AMBER_IRQ_TIMER_LSB     5

`endif

//--- common/amber_sys_pkg.sv
// Shared types for the Amber Wishbone subsystem
// Bus word types, timer count, interrupt vector and decoder FSM states

package amber_sys_pkg;

    // ------------------------------------------------------------------------
    // Wishbone classic bus
    // ------------------------------------------------------------------------

    // Byte address as driven by the master
    typedef logic [31:0] wb_addr_t;

    // Bus data word, also used for any register value
    typedef logic [31:0] wb_data_t;

    // One select bit per byte lane
    typedef logic [3:0]  wb_sel_t;

    // ------------------------------------------------------------------------
    // Timer and interrupt types
    // ------------------------------------------------------------------------

    // Load value or live count of one channel
    typedef logic [15:0] timer_count_t;

    // Raw sources, masks and status share one layout
    typedef logic [31:0] irq_vec_t;

    // Decoder FSM
    // WB_RESP lasts exactly one cycle, the ack or err cycle
    typedef enum logic {
        WB_IDLE,
        WB_RESP
    } wb_state_t;

endpackage

//--- filelist.f
+incdir+common
common/amber_sys_pkg.sv
rtl/boot_mem.sv
rtl/wb_decoder.sv
timer/timer_channel.sv
timer/timer_regs.sv
irq/irq_ctrl.sv
rtl/amber_sys.sv
test/tb_amber_sys.sv

//--- irq/irq_ctrl.sv
// Interrupt controller
// Raw sources, IRQ and FIRQ enable masks, software bit, registered outputs

`timescale 1ns/1ps

`include "amber_sys_defs.svh"

module irq_ctrl import amber_sys_pkg::*; (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_wr,
    input  wb_addr_t                 i_adr,
    input  wb_data_t                 i_wdat,
    input  logic [`AMBER_TIMERS-1:0] i_timer_int,
    output wb_data_t                 o_rdata,
    output logic                     o_irq,
    output logic                     o_firq
);

    irq_vec_t irq_mask_q;
    irq_vec_t firq_mask_q;
    logic     soft_q;
    irq_vec_t raw;
    irq_vec_t irq_status;
    irq_vec_t firq_status;
    logic [7:0] offset;

    assign offset = i_adr[7:0];

    // ------------------------------------------------------------------------
    // Source vector and status
    // ------------------------------------------------------------------------
    always_comb begin
        raw = '0;
        raw[`AMBER_IRQ_SOFT_BIT] = soft_q;
        raw[`AMBER_IRQ_TIMER_LSB +: `AMBER_TIMERS] = i_timer_int;
    end

    assign irq_status  = raw & irq_mask_q;
    assign firq_status = raw & firq_mask_q;

    // Mask set/clear and soft bit, all write-one
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            irq_mask_q  <= '0;
            firq_mask_q <= '0;
            soft_q      <= 1'b0;
            o_irq       <= 1'b0;
            o_firq      <= 1'b0;
        end else begin
            if (i_wr) begin
                case (offset)
                    `AMBER_IRQ_EN_SET:  irq_mask_q  <= irq_mask_q | i_wdat;
                    `AMBER_IRQ_EN_CLR:  irq_mask_q  <= irq_mask_q & ~i_wdat;
                    `AMBER_FIRQ_EN_SET: firq_mask_q <= firq_mask_q | i_wdat;
                    `AMBER_FIRQ_EN_CLR: firq_mask_q <= firq_mask_q & ~i_wdat;
                    `AMBER_SOFT_SET:
                        if (i_wdat[`AMBER_IRQ_SOFT_BIT]) soft_q <= 1'b1;
                    `AMBER_SOFT_CLR:
                        if (i_wdat[`AMBER_IRQ_SOFT_BIT]) soft_q <= 1'b0;
                    default: ;
                endcase
            end
            // Outputs lag the status by one cycle
            o_irq  <= |irq_status;
            o_firq <= |firq_status;
        end
    end

    // ------------------------------------------------------------------------
    // Read-back
    // ------------------------------------------------------------------------
    always_comb begin
        case (offset)
            `AMBER_IRQ_STATUS:  o_rdata = irq_status;
            `AMBER_IRQ_RAW:     o_rdata = raw;
            `AMBER_IRQ_EN_SET:  o_rdata = irq_mask_q;
            `AMBER_IRQ_EN_CLR:  o_rdata = irq_mask_q;
            `AMBER_FIRQ_STATUS: o_rdata = firq_status;
            `AMBER_FIRQ_RAW:    o_rdata = raw;
            `AMBER_FIRQ_EN_SET: o_rdata = firq_mask_q;
            `AMBER_FIRQ_EN_CLR: o_rdata = firq_mask_q;
            // Soft bit in place
            `AMBER_SOFT_SET:    o_rdata = raw & (irq_vec_t'(1) << `AMBER_IRQ_SOFT_BIT);
            `AMBER_SOFT_CLR:    o_rdata = raw & (irq_vec_t'(1) << `AMBER_IRQ_SOFT_BIT);
            default:            o_rdata = '0;
        endcase
    end

endmodule

//--- rtl/amber_sys.sv
// Amber subsystem top level
// Decoder, boot SRAM, timer block and interrupt controller on one slave bus

`timescale 1ns/1ps

`include "amber_sys_defs.svh"

module amber_sys import amber_sys_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,

    // Wishbone slave port, driven by the external master
    input  wb_addr_t i_wb_adr,
    input  wb_sel_t  i_wb_sel,
    input  logic     i_wb_we,
    input  wb_data_t i_wb_dat,
    input  logic     i_wb_cyc,
    input  logic     i_wb_stb,
    output wb_data_t o_wb_dat,
    output logic     o_wb_ack,
    output logic     o_wb_err,

    // Interrupt lines towards the core
    output logic     o_irq,
    output logic     o_firq
);

    // Per-region write strobes and read data
    logic     boot_wr;
    logic     timer_wr;
    logic     irq_wr;
    wb_data_t boot_rdata;
    wb_data_t timer_rdata;
    wb_data_t irq_rdata;

    // Timer register block to channels
    logic [`AMBER_TIMERS-1:0] load_wr;
    logic [`AMBER_TIMERS-1:0] ctrl_wr;
    logic [`AMBER_TIMERS-1:0] clear_wr;
    timer_count_t             timer_count [`AMBER_TIMERS];
    timer_count_t             timer_load  [`AMBER_TIMERS];
    logic [1:0]               timer_ctrl  [`AMBER_TIMERS];
    // Channel flags double as timer interrupt lines
    logic [`AMBER_TIMERS-1:0] timer_int;

    // ------------------------------------------------------------------------
    // Address decode and response
    // ------------------------------------------------------------------------
    wb_decoder u_wb_decoder (
        .i_clk         ( i_clk       ),
        .i_rst_n       ( i_rst_n     ),
        .i_wb_adr      ( i_wb_adr    ),
        .i_wb_we       ( i_wb_we     ),
        .i_wb_cyc      ( i_wb_cyc    ),
        .i_wb_stb      ( i_wb_stb    ),
        .i_boot_rdata  ( boot_rdata  ),
        .i_timer_rdata ( timer_rdata ),
        .i_irq_rdata   ( irq_rdata   ),
        .o_wb_dat      ( o_wb_dat    ),
        .o_wb_ack      ( o_wb_ack    ),
        .o_wb_err      ( o_wb_err    ),
        .o_boot_wr     ( boot_wr     ),
        .o_timer_wr    ( timer_wr    ),
        .o_irq_wr      ( irq_wr      )
    );

    // Boot SRAM
    boot_mem u_boot_mem (
        .i_clk   ( i_clk      ),
        .i_wr    ( boot_wr    ),
        .i_adr   ( i_wb_adr   ),
        .i_sel   ( i_wb_sel   ),
        .i_wdat  ( i_wb_dat   ),
        .o_rdata ( boot_rdata )
    );

    // ------------------------------------------------------------------------
    // Timer block
    // ------------------------------------------------------------------------
    timer_regs u_timer_regs (
        .i_wr       ( timer_wr    ),
        .i_adr      ( i_wb_adr    ),
        .i_count    ( timer_count ),
        .i_load     ( timer_load  ),
        .i_ctrl     ( timer_ctrl  ),
        .i_flag     ( timer_int   ),
        .o_load_wr  ( load_wr     ),
        .o_ctrl_wr  ( ctrl_wr     ),
        .o_clear_wr ( clear_wr    ),
        .o_rdata    ( timer_rdata )
    );

    for (genvar g = 0; g < `AMBER_TIMERS; g++) begin : g_timer
        timer_channel u_timer_channel (
            .i_clk      ( i_clk          ),
            .i_rst_n    ( i_rst_n        ),
            .i_load_wr  ( load_wr[g]     ),
            .i_ctrl_wr  ( ctrl_wr[g]     ),
            .i_clear_wr ( clear_wr[g]    ),
            .i_wdat     ( i_wb_dat       ),
            .o_count    ( timer_count[g] ),
            .o_ctrl     ( timer_ctrl[g]  ),
            .o_load     ( timer_load[g]  ),
            .o_flag     ( timer_int[g]   )
        );
    end

    // Interrupt controller
    irq_ctrl u_irq_ctrl (
        .i_clk       ( i_clk     ),
        .i_rst_n     ( i_rst_n   ),
        .i_wr        ( irq_wr    ),
        .i_adr       ( i_wb_adr  ),
        .i_wdat      ( i_wb_dat  ),
        .i_timer_int ( timer_int ),
        .o_rdata     ( irq_rdata ),
        .o_irq       ( o_irq     ),
        .o_firq      ( o_firq    )
    );

endmodule

//--- rtl/boot_mem.sv
// Boot SRAM, 256 words
// Byte-lane writes on the decoder strobe, combinational read

`timescale 1ns/1ps

`include "amber_sys_defs.svh"

module boot_mem import amber_sys_pkg::*; (
    input  logic     i_clk,
    input  logic     i_wr,
    input  wb_addr_t i_adr,
    input  wb_sel_t  i_sel,
    input  wb_data_t i_wdat,
    output wb_data_t o_rdata
);

    // Word storage
    wb_data_t mem [`AMBER_BOOT_WORDS];

    // Word index from the byte address
    logic [`AMBER_BOOT_AW-1:0] word_idx;

    assign word_idx = i_adr[`AMBER_BOOT_AW+1:2];

    // ------------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------------

    // Only lanes with sel set are replaced
    always_ff @(posedge i_clk) begin
        if (i_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (i_sel[b]) begin
                    mem[word_idx][b*8 +: 8] <= i_wdat[b*8 +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------------

    // Async read, the decoder registers it
    assign o_rdata = mem[word_idx];

endmodule

//--- rtl/wb_decoder.sv
// Wishbone region decoder
// One-cycle ack or err, per-region write strobes, registered read data

`timescale 1ns/1ps

`include "amber_sys_defs.svh"

module wb_decoder import amber_sys_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  wb_addr_t i_wb_adr,
    input  logic     i_wb_we,
    input  logic     i_wb_cyc,
    input  logic     i_wb_stb,
    input  wb_data_t i_boot_rdata,
    input  wb_data_t i_timer_rdata,
    input  wb_data_t i_irq_rdata,
    output wb_data_t o_wb_dat,
    output logic     o_wb_ack,
    output logic     o_wb_err,
    output logic     o_boot_wr,
    output logic     o_timer_wr,
    output logic     o_irq_wr
);

    wb_state_t state_q;
    logic      accept;
    logic      hit_boot;
    logic      hit_timer;
    logic      hit_irq;
    wb_data_t  rdata_sel;

    // New request only taken from idle
    assign accept    = (state_q == WB_IDLE) && i_wb_cyc && i_wb_stb;

    // Region match on the top address byte
    assign hit_boot  = (i_wb_adr[31:24] == `AMBER_REGION_BOOT);
    assign hit_timer = (i_wb_adr[31:24] == `AMBER_REGION_TIMER);
    assign hit_irq   = (i_wb_adr[31:24] == `AMBER_REGION_IRQ);

    // Slaves trust these write strobes without rechecking
    assign o_boot_wr  = accept && i_wb_we && hit_boot;
    assign o_timer_wr = accept && i_wb_we && hit_timer;
    assign o_irq_wr   = accept && i_wb_we && hit_irq;

    always_comb begin
        rdata_sel = '0;
        if (hit_boot) begin
            rdata_sel = i_boot_rdata;
        end else if (hit_timer) begin
            rdata_sel = i_timer_rdata;
        end else if (hit_irq) begin
            rdata_sel = i_irq_rdata;
        end
    end

    // ------------------------------------------------------------------------
    // Response FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q  <= WB_IDLE;
            o_wb_ack <= 1'b0;
            o_wb_err <= 1'b0;
        end else begin
            // WB_RESP always falls back to idle after one cycle
            state_q  <= accept ? WB_RESP : WB_IDLE;
            o_wb_ack <= accept && (hit_boot || hit_timer || hit_irq);
            o_wb_err <= accept && !(hit_boot || hit_timer || hit_irq);
        end
    end

    // Read data captured at accept and valid in the ack cycle
    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_wb_dat <= rdata_sel;
        end
    end

    // Exactly one response kind per response cycle
    a_ack_err_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_wb_ack && o_wb_err));

endmodule

//--- test/tb_amber_sys.sv
// Testbench for the Amber Wishbone subsystem
// Clock and reset, bus tasks, reference model, compare tasks, test scenarios

`timescale 1ns/1ps

`include "amber_sys_defs.svh"

module tb_amber_sys import amber_sys_pkg::*; ();

    localparam int RESP_TIMEOUT = 16;
    localparam int POLL_LIMIT   = 100;
    localparam wb_data_t CTRL_EN  = wb_data_t'(1) << `AMBER_CTRL_ENABLE_BIT;
    localparam wb_data_t CTRL_PER = wb_data_t'(1) << `AMBER_CTRL_PERIODIC_BIT;
    localparam wb_data_t SOFT_BIT = wb_data_t'(1) << `AMBER_IRQ_SOFT_BIT;

    logic     clk;
    logic     rst_n;
    wb_addr_t wb_adr;
    wb_sel_t  wb_sel;
    logic     wb_we;
    wb_data_t wb_dat;
    logic     wb_cyc;
    logic     wb_stb;
    wb_data_t wb_rdat;
    logic     wb_ack;
    logic     wb_err;
    logic     irq;
    logic     firq;

    // Reference model state
    wb_data_t                 boot_model [`AMBER_BOOT_WORDS];
    irq_vec_t                 irq_mask_m;
    irq_vec_t                 firq_mask_m;
    logic                     soft_m;
    logic [`AMBER_TIMERS-1:0] flag_m;
    timer_count_t             load_m [`AMBER_TIMERS];
    wb_data_t                 ctrl_m [`AMBER_TIMERS];
    int                       seed;

    amber_sys u_amber_sys (
        .i_clk    ( clk     ),
        .i_rst_n  ( rst_n   ),
        .i_wb_adr ( wb_adr  ),
        .i_wb_sel ( wb_sel  ),
        .i_wb_we  ( wb_we   ),
        .i_wb_dat ( wb_dat  ),
        .i_wb_cyc ( wb_cyc  ),
        .i_wb_stb ( wb_stb  ),
        .o_wb_dat ( wb_rdat ),
        .o_wb_ack ( wb_ack  ),
        .o_wb_err ( wb_err  ),
        .o_irq    ( irq     ),
        .o_firq   ( firq    )
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Reporting and compare tasks
    // ------------------------------------------------------------------------
    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_data(input string name, input wb_data_t exp, input wb_data_t act);
        if (act !== exp)
            stop_with_failure($sformatf("MISMATCH %s expected 0x%08h actual 0x%08h",
                                        name, exp, act));
    endtask

    // Response kind as {ack, err}
    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp)
            stop_with_failure($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h",
                                        name, exp, act));
    endtask

    // Line pair as {irq, firq}
    task automatic check_irq_lines(input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp)
            stop_with_failure($sformatf("MISMATCH irq_firq expected 0x%0h actual 0x%0h",
                                        exp, act));
    endtask

    task automatic check_count_le(input string name, input timer_count_t bound,
                                  input timer_count_t act);
        if ($isunknown(act) || act > bound)
            stop_with_failure($sformatf("MISMATCH %s expected <= 0x%04h actual 0x%04h",
                                        name, bound, act));
    endtask

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic wb_data_t merge_lanes(input wb_data_t old, input wb_data_t data,
                                             input wb_sel_t sel);
        wb_data_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) res[b*8 +: 8] = data[b*8 +: 8];
        end
        return res;
    endfunction

    // Fill word built from every bit of the word index
    function automatic wb_data_t fill_value(input logic [7:0] idx);
        return {idx ^ 8'h3C, ~idx, idx, idx ^ 8'hC3};
    endfunction

    function automatic wb_addr_t timer_addr(input int k, input logic [7:0] off);
        return {`AMBER_REGION_TIMER, 14'h0, 2'(k), off};
    endfunction

    function automatic wb_addr_t irq_addr(input logic [7:0] off);
        return {`AMBER_REGION_IRQ, 16'h0, off};
    endfunction

    function automatic wb_data_t expected_read(input wb_addr_t adr);
        irq_vec_t raw;
        wb_data_t rd;
        int       ch;
        raw = '0;
        raw[`AMBER_IRQ_SOFT_BIT] = soft_m;
        raw[`AMBER_IRQ_TIMER_LSB +: `AMBER_TIMERS] = flag_m;
        ch = int'(adr[9:8]);
        rd = '0;
        case (adr[31:24])
            `AMBER_REGION_BOOT: rd = boot_model[adr[9:2]];
            `AMBER_REGION_TIMER: begin
                if (ch < `AMBER_TIMERS) begin
                    if (adr[7:0] == `AMBER_TIMER_LOAD) rd = wb_data_t'(load_m[ch]);
                    if (adr[7:0] == `AMBER_TIMER_CTRL) rd = ctrl_m[ch];
                end
            end
            `AMBER_REGION_IRQ: begin
                case (adr[7:0])
                    `AMBER_IRQ_STATUS:                     rd = raw & irq_mask_m;
                    `AMBER_FIRQ_STATUS:                    rd = raw & firq_mask_m;
                    `AMBER_IRQ_RAW, `AMBER_FIRQ_RAW:       rd = raw;
                    `AMBER_IRQ_EN_SET, `AMBER_IRQ_EN_CLR:   rd = irq_mask_m;
                    `AMBER_FIRQ_EN_SET, `AMBER_FIRQ_EN_CLR: rd = firq_mask_m;
                    default:                               rd = '0;
                endcase
            end
            default: rd = '0;
        endcase
        return rd;
    endfunction

    // ------------------------------------------------------------------------
    // Bus tasks entered on a falling edge
    // ------------------------------------------------------------------------
    task automatic wb_transfer(input wb_addr_t adr, input logic we, input wb_data_t data,
                               input wb_sel_t sel, output wb_data_t rdata,
                               output logic [1:0] resp);
        int cycles;
        wb_adr = adr;
        wb_we  = we;
        wb_dat = data;
        wb_sel = sel;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        cycles = 0;
        resp   = 2'b00;
        while (resp == 2'b00) begin
            @(negedge clk);
            resp  = {wb_ack, wb_err};
            rdata = wb_rdat;
            cycles++;
            if (resp == 2'b00 && cycles >= RESP_TIMEOUT)
                stop_with_failure($sformatf("no ack or err within %0d cycles at 0x%08h",
                                            RESP_TIMEOUT, adr));
        end
        // Drop the strobe before the next rising edge
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t data, input wb_sel_t sel,
                            output logic [1:0] resp);
        wb_data_t unused;
        wb_transfer(adr, 1'b1, data, sel, unused, resp);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t data,
                           output logic [1:0] resp);
        wb_transfer(adr, 1'b0, '0, 4'hF, data, resp);
    endtask

    task automatic write_expect(input wb_addr_t adr, input wb_data_t data, input wb_sel_t sel);
        logic [1:0] resp;
        wb_write(adr, data, sel, resp);
        check_resp("wb write response", 2'b10, resp);
    endtask

    task automatic read_expect(input wb_addr_t adr, input string name);
        wb_data_t   data;
        logic [1:0] resp;
        wb_read(adr, data, resp);
        check_resp("wb read response", 2'b10, resp);
        check_data(name, expected_read(adr), data);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Poll the raw vector until the channel's bit shows up
    task automatic wait_for_flag(input int k);
        wb_data_t   data;
        logic [1:0] resp;
        int         polls;
        polls = 0;
        data  = '0;
        while (data[`AMBER_IRQ_TIMER_LSB + k] !== 1'b1) begin
            if (polls >= POLL_LIMIT)
                stop_with_failure($sformatf("timer %0d never raised its interrupt flag", k));
            wb_read(irq_addr(`AMBER_IRQ_RAW), data, resp);
            check_resp("irq raw poll response", 2'b10, resp);
            polls++;
        end
        flag_m[k] = 1'b1;
    endtask

    // ------------------------------------------------------------------------
    // Scenarios
    // ------------------------------------------------------------------------
    initial begin
        wb_data_t     data;
        wb_sel_t      sel;
        logic [7:0]   idx;
        logic [1:0]   resp;
        timer_count_t load;

        seed        = 32'h5141b5bb;
        rst_n       = 1'b0;
        wb_adr      = '0;
        wb_sel      = '0;
        wb_we       = 1'b0;
        wb_dat      = '0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        irq_mask_m  = '0;
        firq_mask_m = '0;
        soft_m      = 1'b0;
        flag_m      = '0;
        for (int k = 0; k < `AMBER_TIMERS; k++) begin
            load_m[k] = '0;
            ctrl_m[k] = '0;
        end

        // Eight rising edges under reset, released on a falling edge
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        idle_cycles(1);

        // Quiet outputs and cleared masks
        check_resp("wb_ack_err after reset", 2'b00, {wb_ack, wb_err});
        check_irq_lines(2'b00, {irq, firq});
        read_expect(irq_addr(`AMBER_IRQ_EN_SET), "irq mask after reset");
        read_expect(irq_addr(`AMBER_FIRQ_EN_SET), "firq mask after reset");

        // Known contents in every boot word
        for (int w = 0; w < `AMBER_BOOT_WORDS; w++) begin
            boot_model[w] = fill_value(8'(w));
            write_expect(wb_addr_t'(w << 2), boot_model[w], 4'hF);
        end

        // Random byte-lane writes with a read-back of each
        for (int n = 0; n < 64; n++) begin
            idx  = 8'($random(seed));
            sel  = wb_sel_t'($random(seed));
            data = wb_data_t'($random(seed));
            write_expect(wb_addr_t'({idx, 2'b00}), data, sel);
            boot_model[idx] = merge_lanes(boot_model[idx], data, sel);
            read_expect(wb_addr_t'({idx, 2'b00}), "boot word");
            idx = 8'($random(seed));
            read_expect(wb_addr_t'({idx, 2'b00}), "boot word");
        end

        // Unmapped region answers with err only
        wb_read(32'h2000_0010, data, resp);
        check_resp("unmapped read response", 2'b01, resp);
        wb_write(32'h2000_0010, 32'hDEAD_BEEF, 4'hF, resp);
        check_resp("unmapped write response", 2'b01, resp);
        wb_write(32'h2000_0000, 32'h1234_5678, 4'hF, resp);
        check_resp("unmapped write response", 2'b01, resp);
        read_expect(32'h0000_0010, "boot word after unmapped write");
        read_expect(32'h0000_0000, "boot word after unmapped write");

        // One-shot run on each channel
        for (int k = 0; k < `AMBER_TIMERS; k++) begin
            load      = timer_count_t'(5 + k);
            load_m[k] = load;
            write_expect(timer_addr(k, `AMBER_TIMER_LOAD), wb_data_t'(load), 4'hF);
            read_expect(timer_addr(k, `AMBER_TIMER_LOAD), "timer load");
            ctrl_m[k] = CTRL_EN;
            write_expect(timer_addr(k, `AMBER_TIMER_CTRL), CTRL_EN, 4'hF);
            read_expect(timer_addr(k, `AMBER_TIMER_CTRL), "timer ctrl");
            wait_for_flag(k);
            // Count parks at zero
            for (int r = 0; r < 4; r++) begin
                wb_read(timer_addr(k, `AMBER_TIMER_VALUE), data, resp);
                check_resp("timer value response", 2'b10, resp);
                check_data("one-shot timer value", '0, data);
            end
            read_expect(irq_addr(`AMBER_IRQ_RAW), "irq raw with timer flag");
            write_expect(timer_addr(k, `AMBER_TIMER_CLEAR), 32'h1, 4'hF);
            flag_m[k] = 1'b0;
            read_expect(irq_addr(`AMBER_IRQ_RAW), "irq raw after clear");
        end

        // Periodic run on channel 0
        ctrl_m[0] = '0;
        write_expect(timer_addr(0, `AMBER_TIMER_CTRL), '0, 4'hF);
        load_m[0] = timer_count_t'(6);
        write_expect(timer_addr(0, `AMBER_TIMER_LOAD), 32'h6, 4'hF);
        ctrl_m[0] = CTRL_EN | CTRL_PER;
        write_expect(timer_addr(0, `AMBER_TIMER_CTRL), CTRL_EN | CTRL_PER, 4'hF);
        read_expect(timer_addr(0, `AMBER_TIMER_CTRL), "timer ctrl periodic");
        wait_for_flag(0);
        for (int r = 0; r < 12; r++) begin
            wb_read(timer_addr(0, `AMBER_TIMER_VALUE), data, resp);
            check_resp("timer value response", 2'b10, resp);
            check_count_le("periodic timer value", load_m[0], timer_count_t'(data[15:0]));
        end
        // Stop before clearing so the flag stays down
        ctrl_m[0] = '0;
        write_expect(timer_addr(0, `AMBER_TIMER_CTRL), '0, 4'hF);
        write_expect(timer_addr(0, `AMBER_TIMER_CLEAR), 32'h1, 4'hF);
        flag_m[0] = 1'b0;
        read_expect(irq_addr(`AMBER_IRQ_RAW), "irq raw after periodic");

        // Soft interrupt through both masks
        write_expect(irq_addr(`AMBER_SOFT_SET), SOFT_BIT, 4'hF);
        soft_m = 1'b1;
        read_expect(irq_addr(`AMBER_IRQ_RAW), "irq raw with soft bit");
        idle_cycles(2);
        check_irq_lines(2'b00, {irq, firq});
        write_expect(irq_addr(`AMBER_IRQ_EN_SET), SOFT_BIT, 4'hF);
        irq_mask_m = irq_mask_m | SOFT_BIT;
        idle_cycles(2);
        check_irq_lines(2'b10, {irq, firq});
        read_expect(irq_addr(`AMBER_IRQ_STATUS), "irq status");
        write_expect(irq_addr(`AMBER_FIRQ_EN_SET), SOFT_BIT, 4'hF);
        firq_mask_m = firq_mask_m | SOFT_BIT;
        idle_cycles(2);
        check_irq_lines(2'b11, {irq, firq});
        read_expect(irq_addr(`AMBER_FIRQ_STATUS), "firq status");
        write_expect(irq_addr(`AMBER_IRQ_EN_CLR), SOFT_BIT, 4'hF);
        irq_mask_m = irq_mask_m & ~SOFT_BIT;
        idle_cycles(2);
        check_irq_lines(2'b01, {irq, firq});
        read_expect(irq_addr(`AMBER_IRQ_STATUS), "irq status masked");
        read_expect(irq_addr(`AMBER_IRQ_EN_SET), "irq mask");
        write_expect(irq_addr(`AMBER_IRQ_EN_SET), SOFT_BIT, 4'hF);
        irq_mask_m = irq_mask_m | SOFT_BIT;
        idle_cycles(2);
        check_irq_lines(2'b11, {irq, firq});
        // Dropping the source silences both lines
        write_expect(irq_addr(`AMBER_SOFT_CLR), SOFT_BIT, 4'hF);
        soft_m = 1'b0;
        idle_cycles(2);
        check_irq_lines(2'b00, {irq, firq});
        read_expect(irq_addr(`AMBER_IRQ_STATUS), "irq status after soft clear");
        read_expect(irq_addr(`AMBER_FIRQ_STATUS), "firq status after soft clear");

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- timer/timer_channel.sv
// One down-counting timer channel
// Load value, enable and periodic bits, sticky interrupt flag

`timescale 1ns/1ps

`include "amber_sys_defs.svh"

module timer_channel import amber_sys_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_load_wr,
    input  logic         i_ctrl_wr,
    input  logic         i_clear_wr,
    input  wb_data_t     i_wdat,
    output timer_count_t o_count,
    output logic [1:0]   o_ctrl,
    output timer_count_t o_load,
    output logic         o_flag
);

    // ctrl[1] enable, ctrl[0] periodic
    logic enable;
    logic periodic;
    logic expire;

    assign enable   = o_ctrl[1];
    assign periodic = o_ctrl[0];

    // Step from 1 to 0 this cycle
    assign expire   = enable && (o_count == timer_count_t'(1)) && !i_load_wr;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_count <= '0;
            o_load  <= '0;
            o_ctrl  <= '0;
            o_flag  <= 1'b0;
        end else begin
            if (i_load_wr) begin
                o_load  <= i_wdat[15:0];
                o_count <= i_wdat[15:0];
            end else if (expire) begin
                // One-shot parks at 0
                o_count <= periodic ? o_load : '0;
            end else if (enable && o_count != '0) begin
                o_count <= o_count - 1'b1;
            end

            if (i_ctrl_wr) begin
                o_ctrl <= {i_wdat[`AMBER_CTRL_ENABLE_BIT], i_wdat[`AMBER_CTRL_PERIODIC_BIT]};
            end

            // Clear beats a set in the same cycle
            if (i_clear_wr) begin
                o_flag <= 1'b0;
            end else if (expire) begin
                o_flag <= 1'b1;
            end
        end
    end

    // Running count stays within the programmed period
    a_count_le_load: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        enable |-> (o_count <= o_load));

endmodule

//--- timer/timer_regs.sv
// Timer register block
// Channel/offset split, per-channel write strobes, read-back mux

`timescale 1ns/1ps

`include "amber_sys_defs.svh"

module timer_regs import amber_sys_pkg::*; (
    input  logic                     i_wr,
    input  wb_addr_t                 i_adr,
    input  timer_count_t             i_count [`AMBER_TIMERS],
    input  timer_count_t             i_load  [`AMBER_TIMERS],
    input  logic [1:0]               i_ctrl  [`AMBER_TIMERS],
    input  logic [`AMBER_TIMERS-1:0] i_flag,
    output logic [`AMBER_TIMERS-1:0] o_load_wr,
    output logic [`AMBER_TIMERS-1:0] o_ctrl_wr,
    output logic [`AMBER_TIMERS-1:0] o_clear_wr,
    output wb_data_t                 o_rdata
);

    // Channel index and register offset
    logic [1:0]                         chan;
    logic [`AMBER_TIMER_STRIDE_BIT-1:0] offset;

    assign chan   = i_adr[`AMBER_TIMER_STRIDE_BIT +: 2];
    assign offset = i_adr[`AMBER_TIMER_STRIDE_BIT-1:0];

    always_comb begin
        o_load_wr  = '0;
        o_ctrl_wr  = '0;
        o_clear_wr = '0;
        o_rdata    = '0;
        // Index 3 is a hole, reads 0 and writes nothing
        for (int k = 0; k < `AMBER_TIMERS; k++) begin
            if (chan == 2'(k)) begin
                o_load_wr[k]  = i_wr && (offset == `AMBER_TIMER_LOAD);
                o_ctrl_wr[k]  = i_wr && (offset == `AMBER_TIMER_CTRL);
                o_clear_wr[k] = i_wr && (offset == `AMBER_TIMER_CLEAR);
                case (offset)
                    `AMBER_TIMER_LOAD:  o_rdata = wb_data_t'(i_load[k]);
                    `AMBER_TIMER_VALUE: o_rdata = wb_data_t'(i_count[k]);
                    `AMBER_TIMER_CTRL: begin
                        // Same bit positions as the write
                        o_rdata[`AMBER_CTRL_ENABLE_BIT]   = i_ctrl[k][1];
                        o_rdata[`AMBER_CTRL_PERIODIC_BIT] = i_ctrl[k][0];
                    end
                    `AMBER_TIMER_CLEAR: o_rdata = wb_data_t'(i_flag[k]);
                    default:            o_rdata = '0;
                endcase
            end
        end
    end

    // One write hits one register of one channel
    always_comb begin
        a_one_strobe: assert final ($onehot0({o_load_wr, o_ctrl_wr, o_clear_wr}));
    end

endmodule
